//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tbLcdController
FILELIST = all.f
BUILD = obj_dir
SIMFLAGS = +verilator+error+limit+1000
PASSTEXT = ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP) $(SIMFLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSTEXT)"

clean:
	rm -rf $(BUILD)

//--- all.f
common/lcdPkg.sv
lcdInit/lcdPowerOnSequencer.sv
lcdWrite/lcdByteWriter.sv
src/lcdCommandSequencer.sv
src/lcdController.sv
sim/lcdController_sva.sv
sim/tbLcdController.sv

//--- common/lcdPkg.sv
package lcdPkg;

	//////////////////////////////
	// Widths

	localparam int nibbleW = 4;	// 4-bit LCD data bus
	localparam int timerW = 20;	// Wide enough for the 15 ms wait

	// One byte seen whole or as its two bus nibbles
	typedef union packed
	{
		logic [2*nibbleW-1:0] raw;	// Host or command table view
		struct packed
		{
			logic [nibbleW-1:0] upper;	// Goes out first
			logic [nibbleW-1:0] lower;	// Goes out second
		} nibbles;
	} lcdByteT;

	//////////////////////////////
	// Byte write timing at 50 MHz

	// Enable high time of every nibble
	localparam logic [timerW-1:0] EnablePulse = timerW'(15);
	// Upper start to lower start, about 1.5 us
	localparam logic [timerW-1:0] NibbleGap = timerW'(75);
	// Lower start to end of write, about 41 us
	localparam logic [timerW-1:0] SettleShort = timerW'(2065);
	// Same for the clear command, about 1.65 ms
	localparam logic [timerW-1:0] SettleClear = timerW'(82515);

	//////////////////////////////
	// Power-on wake-up timing

	// 15 ms of quiet bus after reset
	localparam logic [timerW-1:0] PowerOnWait = timerW'(750000);
	// Gaps measured from each pulse start
	localparam logic [timerW-1:0] WakeGap0 = timerW'(205000);	// 4.1 ms
	localparam logic [timerW-1:0] WakeGap1 = timerW'(5000);	// 100 us
	localparam logic [timerW-1:0] WakeGap2 = timerW'(2000);	// 40 us
	localparam logic [timerW-1:0] WakeGap3 = timerW'(2000);	// 40 us before config

	// Index 0 is sent first
	localparam logic [3:0][nibbleW-1:0] WakeNibbles = {
		4'h2,	// Switch to 4-bit mode
		4'h3,
		4'h3,
		4'h3
	};

	//////////////////////////////
	// Configuration commands

	localparam logic [7:0] CmdFunctionSet = 8'h28;	// 4-bit, two lines, 5x8 font
	localparam logic [7:0] CmdEntryMode = 8'h06;	// Cursor moves right, no shift
	localparam logic [7:0] CmdDisplayOn = 8'h0C;	// Display on, cursor off
	localparam logic [7:0] CmdClear = 8'h01;	// Clear and home, slow

endpackage

//--- lcdInit/lcdPowerOnSequencer.sv
module lcdPowerOnSequencer
(
	input logic Clock,	// 50 MHz
	input logic rstN,	// Async, active low
	output logic wakeEnable,	// Enable during wake-up
	output logic [lcdPkg::nibbleW-1:0] wakeData,	// Wake-up nibble
	output logic wakeDone	// Held high once wake-up is over
);

	import lcdPkg::*;

	//////////////////////////////
	// State

	logic waiting;	// Still in the power-on wait
	logic [1:0] wakeIdx;	// Which wake-up nibble
	logic [timerW-1:0] timer;	// Cycles into current step
	logic [timerW-1:0] stepEnd;	// Last cycle of current step

	//////////////////////////////
	// Step length decode

	always_comb
	begin
		if (waiting)
		begin
			stepEnd = PowerOnWait - timerW'(1);	// Quiet bus first
		end
		else
		begin
			case (wakeIdx)
				2'd0:
				begin
					stepEnd = WakeGap0 - timerW'(1);	// Longest gap
				end
				2'd1:
				begin
					stepEnd = WakeGap1 - timerW'(1);
				end
				2'd2:
				begin
					stepEnd = WakeGap2 - timerW'(1);
				end
				default:
				begin
					stepEnd = WakeGap3 - timerW'(1);	// Before configuration
				end
			endcase
		end
	end

	//////////////////////////////
	// Step walker

	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			waiting <= 1'b1;
			wakeIdx <= 2'd0;
			timer <= '0;
			wakeDone <= 1'b0;
		end
		else if (!wakeDone)	// Frozen once finished
		begin
			if (timer == stepEnd)
			begin
				timer <= '0;	// Next step starts its pulse at zero
				if (waiting)
				begin
					waiting <= 1'b0;	// First wake-up pulse next
				end
				else if (wakeIdx == 2'd3)
				begin
					wakeDone <= 1'b1;	// Hand the bus over
				end
				else
				begin
					wakeIdx <= wakeIdx + 2'd1;
				end
			end
			else
			begin
				timer <= timer + timerW'(1);
			end
		end
	end

	//////////////////////////////
	// Bus outputs

	// Pulse at the head of every wake-up step
	assign wakeEnable = !waiting && !wakeDone && (timer < EnablePulse);
	// Nibble held for the whole step
	assign wakeData = WakeNibbles[wakeIdx];

endmodule

//--- lcdWrite/lcdByteWriter.sv
module lcdByteWriter
(
	input logic Clock,	// 50 MHz
	input logic rstN,	// Async, active low
	input logic writeStart,	// One-cycle start of a byte write
	input lcdPkg::lcdByteT writeByte,	// Byte to send
	input logic writeRs,	// Register select for this byte
	output logic writeDone,	// One-cycle end of a byte write
	output logic lcdEnable,	// LCD enable
	output logic [lcdPkg::nibbleW-1:0] lcdData,	// LCD data nibble
	output logic lcdRegisterSelect	// LCD register select
);

	import lcdPkg::*;

	//////////////////////////////
	// Control state

	logic busy;	// Write in progress
	logic lowerHalf;	// Lower pulse or settle phase
	logic [timerW-1:0] timer;	// Cycles into current half
	logic [timerW-1:0] halfEnd;	// Last cycle of current half
	logic [timerW-1:0] settleEnd;	// Settle length for this byte

	//////////////////////////////
	// Latched byte

	lcdByteT byteHold;	// Byte under transfer
	logic rsHold;	// Its register select
	logic clearHold;	// Byte is the clear command

	// Clear needs the long settle
	assign settleEnd = clearHold ? SettleClear : SettleShort;

	// Upper half ends at the lower start
	assign halfEnd = lowerHalf ? (settleEnd - timerW'(1)) : (NibbleGap - timerW'(1));

	// Sampled only when a new write starts
	always_ff @(posedge Clock)
	begin
		if (writeStart && !busy)
		begin
			byteHold <= writeByte;
			rsHold <= writeRs;
			clearHold <= (writeByte.raw == CmdClear) && !writeRs;	// Command, not a character
		end
	end

	//////////////////////////////
	// Phase counter

	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			lowerHalf <= 1'b0;
			timer <= '0;
			writeDone <= 1'b0;
		end
		else
		begin
			writeDone <= 1'b0;	// Pulse by default
			if (!busy)
			begin
				busy <= writeStart;	// Upper pulse next cycle
				lowerHalf <= 1'b0;
				timer <= '0;
			end
			else if (timer == halfEnd)
			begin
				timer <= '0;	// Restart for lower pulse
				if (lowerHalf)
				begin
					busy <= 1'b0;	// Settle over
					writeDone <= 1'b1;
				end
				else
				begin
					lowerHalf <= 1'b1;	// Upper gap over
				end
			end
			else
			begin
				timer <= timer + timerW'(1);
			end
		end
	end

	//////////////////////////////
	// Bus outputs

	// Head of each half is the pulse
	assign lcdEnable = busy && (timer < EnablePulse);

	// Lower nibble set up as soon as the upper pulse ends
	always_comb
	begin
		if (lowerHalf || (busy && timer >= EnablePulse))
		begin
			lcdData = byteHold.nibbles.lower;
		end
		else
		begin
			lcdData = byteHold.nibbles.upper;
		end
	end

	assign lcdRegisterSelect = rsHold;	// Steady across both nibbles

endmodule

//--- sim/lcdController_sva.sv
module lcdControllerChecks
(
	input logic Clock,
	input logic rstN,
	input logic [7:0] data,
	input logic dataValid,
	input logic readyForData,
	input logic lcdEnable,
	input logic lcdRegisterSelect,
	input logic lcdReadWrite,
	input logic lcdStrataFlashControl,
	input logic [lcdPkg::nibbleW-1:0] lcdData
);

	import lcdPkg::*;

	int failCount = 0;	// Read by the testbench at the end

	//////////////////////////////
	// Bus history

	logic [timerW-1:0] highRun;	// Enable high samples so far
	logic [timerW-1:0] sinceRise;	// Cycles since last pulse start
	logic [7:0] pulseCount;	// Pulse starts seen
	logic [7:0] heldByte;	// Last accepted host byte
	logic [1:0] pendingHalves;	// Its nibbles still to come
	logic riseNow;	// First sample of a pulse
	logic [nibbleW-1:0] charNibble;	// Nibble owed to the host byte

	assign riseNow = lcdEnable && (highRun == '0);
	assign charNibble = (pendingHalves == 2'd2) ? heldByte[7:4] : heldByte[3:0];

	// Wake-up, then 0x28 0x06 0x0C 0x01 as nibble pairs
	function automatic logic [3:0] expectedNibble(input logic [7:0] idx);
		case (idx)
			8'd0, 8'd1, 8'd2: return 4'h3;
			8'd3, 8'd4: return 4'h2;
			8'd5: return 4'h8;
			8'd7: return 4'h6;
			8'd9: return 4'hC;
			8'd11: return 4'h1;
			default: return 4'h0;	// Upper nibbles of 0x06 0x0C 0x01
		endcase
	endfunction

	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			highRun <= '0;
			sinceRise <= '0;
			pulseCount <= '0;
			heldByte <= '0;
			pendingHalves <= '0;
		end
		else
		begin
			highRun <= lcdEnable ? highRun + timerW'(1) : '0;
			if (riseNow)
			begin
				pulseCount <= pulseCount + 8'd1;
				sinceRise <= timerW'(1);
				if (pendingHalves != 2'd0)
				begin
					pendingHalves <= pendingHalves - 2'd1;	// One half sent
				end
			end
			else if (sinceRise != '1)
			begin
				sinceRise <= sinceRise + timerW'(1);	// Saturates
			end
			if (readyForData && dataValid)
			begin
				heldByte <= data;	// Handshake fires
				pendingHalves <= 2'd2;
			end
		end
	end

	//////////////////////////////
	// Reset and tie-offs

	resetQuiet: assert property (@(posedge Clock)
		(!rstN || $rose(rstN)) |-> !lcdEnable && !readyForData)
		else
		begin
			failCount++;
			$error("lcdEnable or readyForData high during reset or just after it");
		end

	tiesHeld: assert property (@(posedge Clock) !lcdReadWrite && lcdStrataFlashControl)
		else
		begin
			failCount++;
			$error("FAIL lcdReadWrite %h expected 0, lcdStrataFlashControl %h expected 1",
				$sampled(lcdReadWrite), $sampled(lcdStrataFlashControl));
		end

	//////////////////////////////
	// Pulse shape

	pulseLength: assert property (@(posedge Clock)
		lcdEnable ? (highRun < EnablePulse) : (highRun == '0 || highRun == EnablePulse))
		else
		begin
			failCount++;
			$error("FAIL lcdEnable high cycles %h expected %h", $sampled(highRun), EnablePulse);
		end

	busSteady: assert property (@(posedge Clock)
		lcdEnable && !riseNow |-> $stable(lcdData) && $stable(lcdRegisterSelect))
		else
		begin
			failCount++;
			$error("lcdData or lcdRegisterSelect changed while lcdEnable was high");
		end

	//////////////////////////////
	// Nibble order

	configNibble: assert property (@(posedge Clock)
		riseNow && pulseCount < 8'd12 |->
		lcdData == expectedNibble(pulseCount) && !lcdRegisterSelect)
		else
		begin
			failCount++;
			$error("FAIL lcdData %h expected %h with lcdRegisterSelect %h expected 0",
				$sampled(lcdData), expectedNibble($sampled(pulseCount)),
				$sampled(lcdRegisterSelect));
		end

	charNibbleSent: assert property (@(posedge Clock)
		riseNow && pendingHalves != 2'd0 |-> lcdData == charNibble && lcdRegisterSelect)
		else
		begin
			failCount++;
			$error("FAIL lcdData %h expected %h with lcdRegisterSelect %h expected 1",
				$sampled(lcdData), $sampled(charNibble), $sampled(lcdRegisterSelect));
		end

	//////////////////////////////
	// Host handshake

	readyGated: assert property (@(posedge Clock)
		readyForData |-> pulseCount >= 8'd12 && pendingHalves == 2'd0 &&
		(pulseCount != 8'd12 || sinceRise > SettleClear))
		else
		begin
			failCount++;
			$error("readyForData high before the previous write had ended");
		end

	readyDrops: assert property (@(posedge Clock) readyForData && dataValid |=> !readyForData)
		else
		begin
			failCount++;
			$error("readyForData still high the cycle after a byte was accepted");
		end

endmodule

bind lcdController lcdControllerChecks checks0 (
	.Clock(Clock),
	.rstN(rstN),
	.data(data),
	.dataValid(dataValid),
	.readyForData(readyForData),
	.lcdEnable(lcdEnable),
	.lcdRegisterSelect(lcdRegisterSelect),
	.lcdReadWrite(lcdReadWrite),
	.lcdStrataFlashControl(lcdStrataFlashControl),
	.lcdData(lcdData)
);

//--- sim/tbLcdController.sv
module tbLcdController;

	import lcdPkg::*;

	//////////////////////////////
	// Run length

	localparam int ClockPeriod = 20;
	localparam int PowerOnCycles = int'(PowerOnWait) + int'(WakeGap0) + int'(WakeGap1)
		+ int'(WakeGap2) + int'(WakeGap3);
	// Four commands and four characters at worst case
	localparam int WriteCycles = 8 * (int'(SettleClear) + int'(NibbleGap));
	localparam int WatchdogCycles = PowerOnCycles + WriteCycles + 20000;	// Margin for reset and host gaps

	logic Clock;
	logic rstN;
	logic [7:0] data;
	logic dataValid;
	logic readyForData;
	logic lcdEnable;
	logic lcdRegisterSelect;
	logic lcdReadWrite;
	logic lcdStrataFlashControl;
	logic [nibbleW-1:0] lcdData;

	int seed = 23;	// $random state
	int timeoutCount = 0;

	lcdController dut0 (
		.Clock(Clock),
		.rstN(rstN),
		.data(data),
		.dataValid(dataValid),
		.readyForData(readyForData),
		.lcdEnable(lcdEnable),
		.lcdRegisterSelect(lcdRegisterSelect),
		.lcdReadWrite(lcdReadWrite),
		.lcdStrataFlashControl(lcdStrataFlashControl),
		.lcdData(lcdData)
	);

	initial
	begin
		Clock = 1'b0;
		forever
		begin
			#(ClockPeriod / 2) Clock = ~Clock;
		end
	end

	// Offers one byte after a random pause and holds it until taken
	task automatic sendByte(input logic [7:0] value, input logic afterReady);
		int idle;
		logic taken;
		idle = $unsigned($random(seed)) % 12;
		while (afterReady && !readyForData)	// Pause starts with ready already high
		begin
			@(posedge Clock);
			#1;
		end
		repeat (idle + 1)
		begin
			@(posedge Clock);
		end
		#1;
		data = value;
		dataValid = 1'b1;
		taken = 1'b0;
		while (!taken)
		begin
			taken = readyForData;	// Next edge accepts
			@(posedge Clock);
			#1;
		end
		dataValid = 1'b0;
		data = 8'($random(seed));	// Junk while idle
	endtask

	task automatic finishRun;
		int assertFails;
		assertFails = dut0.checks0.failCount;
		$display("Error counts: %0d assertion failures, %0d timeouts",
			assertFails, timeoutCount);
		if (assertFails == 0 && timeoutCount == 0)
		begin
			$display("ALL CHECKS PASSED");
		end
		else
		begin
			$display("CHECKS FAILED");
		end
		$finish;
	endtask

	//////////////////////////////
	// Watchdog

	initial
	begin
		#(WatchdogCycles * ClockPeriod);
		timeoutCount = timeoutCount + 1;
		$display("Watchdog expired before the last host byte was written");
		finishRun();
	end

	//////////////////////////////
	// Stimulus

	initial
	begin
		rstN = 1'b1;
		data = '0;
		dataValid = 1'b0;
		#1;
		rstN = 1'b0;	// Async reset ahead of the first edge
		repeat (8)
		begin
			@(posedge Clock);
		end
		#1;
		rstN = 1'b1;
		for (int i = 0; i < 4; i++)
		begin
			sendByte(8'($random(seed)), (i % 2) == 1);	// Odd bytes find ready waiting
		end
		while (!readyForData)	// Until last character written
		begin
			@(posedge Clock);
			#1;
		end
		repeat (4)
		begin
			@(posedge Clock);
		end
		finishRun();
	end

endmodule

//--- src/lcdCommandSequencer.sv
module lcdCommandSequencer
(
	input logic Clock,	// 50 MHz
	input logic rstN,	// Async, active low
	input logic wakeDone,	// Wake-up finished
	input logic writeDone,	// Byte writer finished
	input logic [7:0] data,	// Host byte
	input logic dataValid,	// Host byte valid
	output logic writeStart,	// Start pulse to byte writer
	output lcdPkg::lcdByteT writeByte,	// Byte for byte writer
	output logic writeRs,	// Register select for byte writer
	output logic readyForData	// Free to take a host byte
);

	import lcdPkg::*;

	//////////////////////////////
	// Command table

	function automatic logic [7:0] cmdTable(input logic [1:0] idx);
		case (idx)
			2'd0: return CmdFunctionSet;
			2'd1: return CmdEntryMode;
			2'd2: return CmdDisplayOn;
			default: return CmdClear;	// Last, long settle
		endcase
	endfunction

	//////////////////////////////
	// State

	logic configDone;	// All four commands written
	logic writeBusy;	// Configuration write in flight
	logic [1:0] cmdIdx;	// Command being written
	logic [1:0] cmdSel;	// Command to issue now
	logic startFirst;	// Function set right after wake-up
	logic chainNext;	// Next command after a done
	logic accept;	// Host handshake fires

	assign startFirst = !configDone && !writeBusy && wakeDone;
	assign chainNext = !configDone && writeDone && (cmdIdx != 2'd3);
	assign accept = configDone && readyForData && dataValid;

	// Chained command is one past the finished one
	assign cmdSel = startFirst ? cmdIdx : (cmdIdx + 2'd1);

	//////////////////////////////
	// Byte to writer

	always_ff @(posedge Clock)
	begin
		if (startFirst || chainNext)
		begin
			writeByte.raw <= cmdTable(cmdSel);
			writeRs <= 1'b0;	// Instruction register
		end
		else if (accept)
		begin
			writeByte.raw <= data;	// Character
			writeRs <= 1'b1;	// Data register
		end
	end

	//////////////////////////////
	// Sequence control

	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			configDone <= 1'b0;
			writeBusy <= 1'b0;
			cmdIdx <= 2'd0;
			writeStart <= 1'b0;
			readyForData <= 1'b0;
		end
		else
		begin
			writeStart <= startFirst || chainNext || accept;	// One write in flight
			if (startFirst)
			begin
				writeBusy <= 1'b1;
			end
			else if (chainNext)
			begin
				cmdIdx <= cmdIdx + 2'd1;
			end
			else if (!configDone && writeDone)
			begin
				configDone <= 1'b1;	// Clear finished
				writeBusy <= 1'b0;
				readyForData <= 1'b1;
			end
			else if (accept)
			begin
				readyForData <= 1'b0;	// Hold off until written
			end
			else if (configDone && writeDone)
			begin
				readyForData <= 1'b1;	// Character finished
			end
		end
	end

endmodule

//--- src/lcdController.sv
module lcdController
(
	input logic Clock,	// 50 MHz
	input logic rstN,	// Async, active low
	input logic [7:0] data,	// Host byte
	input logic dataValid,	// Host byte valid
	output logic readyForData,	// Free to take a host byte
	output logic lcdEnable,	// LCD enable
	output logic lcdRegisterSelect,	// 0 command, 1 character
	output logic lcdReadWrite,	// Write only
	output logic lcdStrataFlashControl,	// Flash kept off the shared bus
	output logic [lcdPkg::nibbleW-1:0] lcdData	// LCD data nibble
);

	import lcdPkg::*;

	//////////////////////////////
	// Internal wiring

	logic wakeEnable;	// From power-on sequencer
	logic [nibbleW-1:0] wakeData;
	logic wakeDone;

	logic writeStart;	// Sequencer to byte writer
	lcdByteT writeByte;
	logic writeRs;
	logic writeDone;

	logic byteEnable;	// From byte writer
	logic [nibbleW-1:0] byteData;
	logic byteRs;

	lcdPowerOnSequencer powerOn0 (
		.Clock(Clock),
		.rstN(rstN),
		.wakeEnable(wakeEnable),
		.wakeData(wakeData),
		.wakeDone(wakeDone)
	);

	lcdCommandSequencer cmdSeq0 (
		.Clock(Clock),
		.rstN(rstN),
		.wakeDone(wakeDone),
		.writeDone(writeDone),
		.data(data),
		.dataValid(dataValid),
		.writeStart(writeStart),
		.writeByte(writeByte),
		.writeRs(writeRs),
		.readyForData(readyForData)
	);

	lcdByteWriter byteWriter0 (
		.Clock(Clock),
		.rstN(rstN),
		.writeStart(writeStart),
		.writeByte(writeByte),
		.writeRs(writeRs),
		.writeDone(writeDone),
		.lcdEnable(byteEnable),
		.lcdData(byteData),
		.lcdRegisterSelect(byteRs)
	);

	//////////////////////////////
	// LCD bus select

	assign lcdEnable = wakeDone ? byteEnable : wakeEnable;
	assign lcdData = wakeDone ? byteData : wakeData;
	assign lcdRegisterSelect = wakeDone && byteRs;	// Wake-up nibbles are commands

	assign lcdReadWrite = 1'b0;	// Never reads busy flag
	assign lcdStrataFlashControl = 1'b1;

endmodule
